/* rtl/term_pkg.sv */
// terminal router package with terminal addresses, bus widths and memory command limits
`default_nettype none

package term_pkg;

   typedef logic [15:0] term_addr_t;
   typedef logic [31:0] reg_addr_t;
   typedef logic [31:0] word_t;
   typedef logic [15:0] status_t;

   // memory controller user port fields
   typedef logic [2:0]  mem_instr_t;
   typedef logic [5:0]  mem_bl_t;
   typedef logic [29:0] mem_addr_t;

   // word counts up to READ_AHEAD_WORDS plus one burst
   typedef logic [6:0]  word_cnt_t;

   localparam term_addr_t TERM_DRAM       = 16'd2;
   localparam term_addr_t TERM_DUMMY_FPGA = 16'd255;

   // odd register address, the even one gets the inverse
   localparam word_t DUMMY_PATTERN = 32'hBBAA9988;

   localparam mem_instr_t MEM_INSTR_WRITE = 3'd0;
   localparam mem_instr_t MEM_INSTR_READ  = 3'd1;

   localparam int BURST_WORDS      = 16;
   localparam int READ_AHEAD_WORDS = 32;
   localparam int BYTES_PER_WORD   = 4;

   localparam int CMD_QUEUE_DEPTH = 4;
   localparam int CMD_QUEUE_PTR_W = $clog2(CMD_QUEUE_DEPTH);

   typedef logic [CMD_QUEUE_PTR_W-1:0] queue_ptr_t;
   typedef logic [CMD_QUEUE_PTR_W:0]   queue_cnt_t;

endpackage

`default_nettype wire

/* rtl/dram_cmd_if.sv */
// memory command link from the command builder into the command queue
`timescale 1ns/1ns
`default_nettype none

interface dram_cmd_if import term_pkg::*; ();

   // one command per cycle with push high and full low
   logic       push;
   mem_instr_t instr;
   mem_bl_t    bl;
   mem_addr_t  byte_addr;

   // queue at capacity
   logic       full;

   modport builder (
      output push,
      output instr,
      output bl,
      output byte_addr,
      input  full
   );

   modport queue (
      input  push,
      input  instr,
      input  bl,
      input  byte_addr,
      output full
   );

endinterface

`default_nettype wire

/* rtl/terminal_mux.sv */
// terminal mux, decodes the host terminal address and selects the answering terminal
`timescale 1ns/1ns
`default_nettype none

module terminal_mux import term_pkg::*; (
   input  wire term_addr_t di_term_addr,
   input  wire reg_addr_t  di_reg_addr,
   input  wire             di_read,
   input  wire             di_write,
   input  wire             di_read_mode,
   input  wire             di_write_mode,

   input  wire             pt_read_rdy,
   input  wire             pt_write_rdy,
   input  wire word_t      pt_reg_datao,
   input  wire status_t    pt_transfer_status,

   input  wire             dram_read_rdy,
   input  wire             dram_write_rdy,
   input  wire word_t      dram_reg_datao,

   output logic            dram_read,
   output logic            dram_write,
   output logic            dram_read_mode,
   output logic            dram_write_mode,

   output logic            di_read_rdy,
   output logic            di_write_rdy,
   output word_t           di_reg_datao,
   output status_t         di_transfer_status
);

   logic term_dram;
   logic term_dummy;

   assign term_dram  = (di_term_addr == TERM_DRAM);
   assign term_dummy = (di_term_addr == TERM_DUMMY_FPGA);

   // dram path only sees its own traffic
   assign dram_read       = term_dram & di_read;
   assign dram_write      = term_dram & di_write;
   assign dram_read_mode  = term_dram & di_read_mode;
   assign dram_write_mode = term_dram & di_write_mode;

   always_comb begin
      if (term_dram) begin
         di_reg_datao       = dram_reg_datao;
         di_read_rdy        = dram_read_rdy;
         di_write_rdy       = dram_write_rdy;
         // dram terminal never flags an error
         di_transfer_status = '0;
      end else if (term_dummy) begin
         di_reg_datao       = di_reg_addr[0] ? DUMMY_PATTERN : ~DUMMY_PATTERN;
         di_read_rdy        = 1'b1;
         di_write_rdy       = 1'b1;
         di_transfer_status = '0;
      end else begin
         // everything else belongs to the project logic
         di_reg_datao       = pt_reg_datao;
         di_read_rdy        = pt_read_rdy;
         di_write_rdy       = pt_write_rdy;
         di_transfer_status = pt_transfer_status;
      end
   end

endmodule

`default_nettype wire

/* rtl/dram_cmd_builder.sv */
// dram terminal, turns host strobes into memory port write data, burst commands and read pops
`timescale 1ns/1ns
`default_nettype none

module dram_cmd_builder import term_pkg::*; (
   input  wire             ifclk,
   input  wire             rst,
   input  wire             dram_read,
   input  wire             dram_write,
   input  wire             dram_read_mode,
   input  wire             dram_write_mode,
   input  wire reg_addr_t  di_reg_addr,
   input  wire word_t      di_len,
   input  wire word_t      di_reg_datai,
   input  wire word_t      mem_rd_data,
   input  wire             mem_rd_empty,

   output logic            dram_read_rdy,
   output logic            dram_write_rdy,
   output word_t           dram_reg_datao,
   output logic            mem_wr_en,
   output word_t           mem_wr_data,
   output logic            mem_rd_en,

   dram_cmd_if.builder     cmd
);

   typedef enum logic [1:0] {
      idle,
      writing,
      write_flush,
      reading
   } state_t;

   state_t    state;
   word_cnt_t wr_pend;
   word_cnt_t wr_pend_next;
   word_cnt_t rd_burst;
   word_cnt_t rd_flight;
   word_cnt_t cmd_words;
   word_t     rd_left;
   mem_addr_t next_addr;
   logic      burst_full;
   logic      wr_push;
   logic      rd_push;
   logic      start;

   assign start      = (state == idle) && (dram_write_mode || dram_read_mode);
   assign burst_full = (wr_pend == word_cnt_t'(BURST_WORDS));

   // full burst leaves as soon as the queue has room, flush takes whatever is left
   assign wr_push = !cmd.full &&
                    ((state == writing && burst_full) || state == write_flush);

   assign rd_burst = (rd_left > BURST_WORDS) ? word_cnt_t'(BURST_WORDS)
                                              : word_cnt_t'(rd_left);

   // keep issued but unpopped words within the read-ahead window
   assign rd_push = !cmd.full && (state == reading) && (rd_left != '0) &&
                    (rd_flight + rd_burst <= READ_AHEAD_WORDS);

   assign cmd_words    = wr_push ? wr_pend : rd_burst;
   assign wr_pend_next = (wr_push ? word_cnt_t'(0) : wr_pend) + word_cnt_t'(dram_write);

   assign cmd.push      = wr_push | rd_push;
   assign cmd.instr     = wr_push ? MEM_INSTR_WRITE : MEM_INSTR_READ;
   assign cmd.bl        = mem_bl_t'(cmd_words - 1'b1);
   assign cmd.byte_addr = next_addr;

   assign dram_write_rdy = !(burst_full && cmd.full);

   // read side is the memory read fifo itself
   assign dram_read_rdy  = !mem_rd_empty;
   assign dram_reg_datao = mem_rd_data;
   assign mem_rd_en      = dram_read;

   always_ff @(posedge ifclk) begin
      if (rst) begin
         state     <= idle;
         wr_pend   <= '0;
         rd_left   <= '0;
         rd_flight <= '0;
         mem_wr_en <= 1'b0;
      end else begin
         mem_wr_en <= dram_write;
         wr_pend   <= wr_pend_next;
         rd_flight <= rd_flight + (rd_push ? rd_burst : word_cnt_t'(0))
                      - word_cnt_t'(mem_rd_en);

         case (state)
            idle: begin
               if (dram_write_mode) begin
                  state <= writing;
               end else if (dram_read_mode) begin
                  rd_left <= di_len;
                  state   <= reading;
               end
            end
            writing: begin
               // mode fell, send out the tail if any words are left
               if (!dram_write_mode) begin
                  state <= (wr_pend_next != '0) ? write_flush : idle;
               end
            end
            write_flush: begin
               if (wr_push) begin
                  state <= idle;
               end
            end
            reading: begin
               if (rd_push) begin
                  rd_left <= rd_left - rd_burst;
               end
               if (!dram_read_mode) begin
                  rd_left <= '0;
                  state   <= idle;
               end
            end
            default: state <= idle;
         endcase
      end
   end

   // base byte address on mode rise, then advance by each command's words
   always_ff @(posedge ifclk) begin
      mem_wr_data <= di_reg_datai;
      if (start) begin
         next_addr <= mem_addr_t'(di_reg_addr * BYTES_PER_WORD);
      end else if (cmd.push) begin
         next_addr <= next_addr + mem_addr_t'(cmd_words * BYTES_PER_WORD);
      end
   end

endmodule

`default_nettype wire

/* rtl/dram_cmd_queue.sv */
// command fifo between the builder and the memory port, holds commands while the port is full
`timescale 1ns/1ns
`default_nettype none

module dram_cmd_queue import term_pkg::*; (
   input  wire          ifclk,
   input  wire          rst,
   input  wire          mem_cmd_full,

   dram_cmd_if.queue    cmd,

   output logic         mem_cmd_en,
   output mem_instr_t   mem_cmd_instr,
   output mem_bl_t      mem_cmd_bl,
   output mem_addr_t    mem_cmd_byte_addr
);

   mem_instr_t instr_q [CMD_QUEUE_DEPTH];
   mem_bl_t    bl_q    [CMD_QUEUE_DEPTH];
   mem_addr_t  addr_q  [CMD_QUEUE_DEPTH];

   queue_ptr_t wr_ptr;
   queue_ptr_t rd_ptr;
   queue_cnt_t fill;
   logic       push;

   assign cmd.full = (fill == queue_cnt_t'(CMD_QUEUE_DEPTH));
   assign push     = cmd.push && !cmd.full;

   // head command goes out whenever the port takes it
   assign mem_cmd_en        = (fill != '0) && !mem_cmd_full;
   assign mem_cmd_instr     = instr_q[rd_ptr];
   assign mem_cmd_bl        = bl_q[rd_ptr];
   assign mem_cmd_byte_addr = addr_q[rd_ptr];

   always_ff @(posedge ifclk) begin
      if (push) begin
         instr_q[wr_ptr] <= cmd.instr;
         bl_q[wr_ptr]    <= cmd.bl;
         addr_q[wr_ptr]  <= cmd.byte_addr;
      end
   end

   always_ff @(posedge ifclk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (mem_cmd_en) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, mem_cmd_en})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
      end
   end

endmodule

`default_nettype wire

/* rtl/term_router_top.sv */
// terminal router top, connects host transfers to the dummy, dram and project terminals
`timescale 1ns/1ns
`default_nettype none

module term_router_top import term_pkg::*; (
   input  wire             ifclk,
   input  wire             rst,

   // host side
   input  wire term_addr_t di_term_addr,
   input  wire reg_addr_t  di_reg_addr,
   input  wire word_t      di_len,
   input  wire             di_read_mode,
   input  wire             di_write_mode,
   input  wire             di_read,
   input  wire             di_write,
   input  wire word_t      di_reg_datai,
   output logic            di_read_rdy,
   output logic            di_write_rdy,
   output word_t           di_reg_datao,
   output status_t         di_transfer_status,

   // project terminal responses
   input  wire             pt_read_rdy,
   input  wire             pt_write_rdy,
   input  wire word_t      pt_reg_datao,
   input  wire status_t    pt_transfer_status,

   // memory controller user port
   output logic            mem_cmd_en,
   output mem_instr_t      mem_cmd_instr,
   output mem_bl_t         mem_cmd_bl,
   output mem_addr_t       mem_cmd_byte_addr,
   input  wire             mem_cmd_full,
   output logic            mem_wr_en,
   output word_t           mem_wr_data,
   output logic            mem_rd_en,
   input  wire word_t      mem_rd_data,
   input  wire             mem_rd_empty
);

   logic  dram_read;
   logic  dram_write;
   logic  dram_read_mode;
   logic  dram_write_mode;
   logic  dram_read_rdy;
   logic  dram_write_rdy;
   word_t dram_reg_datao;

   dram_cmd_if cmd_link ();

   terminal_mux u_terminal_mux (
      .di_term_addr       (di_term_addr),
      .di_reg_addr        (di_reg_addr),
      .di_read            (di_read),
      .di_write           (di_write),
      .di_read_mode       (di_read_mode),
      .di_write_mode      (di_write_mode),
      .pt_read_rdy        (pt_read_rdy),
      .pt_write_rdy       (pt_write_rdy),
      .pt_reg_datao       (pt_reg_datao),
      .pt_transfer_status (pt_transfer_status),
      .dram_read_rdy      (dram_read_rdy),
      .dram_write_rdy     (dram_write_rdy),
      .dram_reg_datao     (dram_reg_datao),
      .dram_read          (dram_read),
      .dram_write         (dram_write),
      .dram_read_mode     (dram_read_mode),
      .dram_write_mode    (dram_write_mode),
      .di_read_rdy        (di_read_rdy),
      .di_write_rdy       (di_write_rdy),
      .di_reg_datao       (di_reg_datao),
      .di_transfer_status (di_transfer_status)
   );

   dram_cmd_builder u_dram_cmd_builder (
      .ifclk           (ifclk),
      .rst             (rst),
      .dram_read       (dram_read),
      .dram_write      (dram_write),
      .dram_read_mode  (dram_read_mode),
      .dram_write_mode (dram_write_mode),
      .di_reg_addr     (di_reg_addr),
      .di_len          (di_len),
      .di_reg_datai    (di_reg_datai),
      .mem_rd_data     (mem_rd_data),
      .mem_rd_empty    (mem_rd_empty),
      .dram_read_rdy   (dram_read_rdy),
      .dram_write_rdy  (dram_write_rdy),
      .dram_reg_datao  (dram_reg_datao),
      .mem_wr_en       (mem_wr_en),
      .mem_wr_data     (mem_wr_data),
      .mem_rd_en       (mem_rd_en),
      .cmd             (cmd_link.builder)
   );

   dram_cmd_queue u_dram_cmd_queue (
      .ifclk             (ifclk),
      .rst               (rst),
      .mem_cmd_full      (mem_cmd_full),
      .cmd               (cmd_link.queue),
      .mem_cmd_en        (mem_cmd_en),
      .mem_cmd_instr     (mem_cmd_instr),
      .mem_cmd_bl        (mem_cmd_bl),
      .mem_cmd_byte_addr (mem_cmd_byte_addr)
   );

endmodule

`default_nettype wire

/* testbench/tb_term_router.sv */
// testbench for the terminal router, random host transfers against a memory port model
`timescale 1ns/1ns
`default_nettype none

module tb_term_router import term_pkg::*; ();

   localparam int N_XFER = 5;

   logic        ifclk = 1'b0;
   logic        rst;
   term_addr_t  di_term_addr;
   reg_addr_t   di_reg_addr;
   word_t       di_len, di_reg_datai, di_reg_datao, pt_reg_datao, mem_wr_data, mem_rd_data;
   logic        di_read_mode, di_write_mode, di_read, di_write, di_read_rdy, di_write_rdy;
   logic        pt_read_rdy, pt_write_rdy, mem_cmd_en, mem_cmd_full, mem_wr_en, mem_rd_en;
   logic        mem_rd_empty;
   status_t     di_transfer_status, pt_transfer_status;
   mem_instr_t  mem_cmd_instr, exp_instr;
   mem_bl_t     mem_cmd_bl;
   mem_addr_t   mem_cmd_byte_addr, exp_addr;

   // memory port model and host reference
   word_t       mem_model [1024];
   word_t       ref_mem [1024];
   word_t       wr_fifo [$];
   word_t       rd_fifo [$];
   int          exp_left, strobes, errors, checks, cycles, limit;
   int          wl [2*N_XFER];
   int          rl [2*N_XFER];
   int          wa [2*N_XFER];
   logic        busy;
   logic [15:0] host_lfsr = 16'd46928;
   logic [15:0] full_lfsr = 16'd46928;

   term_router_top dut (.*);

   always #20 ifclk = ~ifclk;

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         host_lfsr = lfsr_next(host_lfsr);
         v = {v[30:0], host_lfsr[0]};
      end
      return v;
   endfunction

   task automatic check(input logic ok, input string what);
      checks++;
      assert (ok) else begin
         errors++;
         $display("[ERROR] %0t ns: %s", $time, what);
      end
   endtask

   task automatic report_test(input string name, input int mark);
      $display("test %-14s %0d errors", name, errors - mark);
   endtask

   always @(posedge ifclk) begin : memory_port
      int n;
      int base;
      if (!rst) begin
         strobes = strobes + (mem_cmd_en | mem_wr_en | mem_rd_en);
         if (mem_wr_en)
            wr_fifo.push_back(mem_wr_data);
         if (mem_rd_en && rd_fifo.size() == 0) begin
            errors++;
            $display("the host popped an empty memory read fifo at %0t ns", $time);
         end else if (mem_rd_en) begin
            void'(rd_fifo.pop_front());
         end
         if (mem_cmd_en) begin
            n    = mem_cmd_bl + 1;
            base = mem_cmd_byte_addr >> 2;
            check(!mem_cmd_full, "command issued while mem_cmd_full is high");
            check(mem_cmd_instr == exp_instr, $sformatf("instr %0d, expected %0d",
                  mem_cmd_instr, exp_instr));
            check(mem_cmd_byte_addr == exp_addr, $sformatf("byte address %h, expected %h",
                  mem_cmd_byte_addr, exp_addr));
            check(n <= BURST_WORDS && n <= exp_left, $sformatf("burst of %0d words, %0d left",
                  n, exp_left));
            exp_addr = exp_addr + mem_addr_t'(n * BYTES_PER_WORD);
            exp_left = (n > exp_left) ? 0 : exp_left - n;
            for (int i = 0; i < n; i++) begin
               if (mem_cmd_instr == MEM_INSTR_READ) begin
                  rd_fifo.push_back(mem_model[(base + i) % 1024]);
               end else if (wr_fifo.size() == 0) begin
                  errors++;
                  $display("write command found no write data at %0t ns", $time);
               end else begin
                  mem_model[(base + i) % 1024] = wr_fifo.pop_front();
               end
            end
            check(rd_fifo.size() <= READ_AHEAD_WORDS, "read words in flight above the limit");
         end
         if (wr_fifo.size() > 64 || rd_fifo.size() > 64) begin
            errors++;
            $display("memory model data fifo overflow at %0t ns", $time);
         end
      end
      full_lfsr = lfsr_next(full_lfsr);
      mem_cmd_full <= busy & full_lfsr[0];
      mem_rd_empty <= (rd_fifo.size() == 0);
      mem_rd_data  <= (rd_fifo.size() != 0) ? rd_fifo[0] : '0;
   end

   always @(posedge ifclk) begin
      cycles++;
      if (cycles > limit) begin
         $display("timeout after %0d cycles, the transfers did not finish", cycles);
         $display("Verification failed");
         $finish;
      end
   end

   task automatic write_xfer(input int a, input int len);
      word_t d;
      @(negedge ifclk);
      exp_instr = MEM_INSTR_WRITE;
      exp_addr  = mem_addr_t'(a * BYTES_PER_WORD);
      exp_left  = len;
      @(posedge ifclk);
      di_reg_addr   <= a;
      di_write_mode <= 1'b1;
      for (int i = 0; i < len; i++) begin
         d = rand_bits(32);
         ref_mem[a + i] = d;
         repeat (rand_bits(1)) @(posedge ifclk);
         @(negedge ifclk);
         while (!di_write_rdy) @(negedge ifclk);
         @(posedge ifclk);
         di_write     <= 1'b1;
         di_reg_datai <= d;
         @(posedge ifclk);
         di_write <= 1'b0;
      end
      @(posedge ifclk);
      di_write_mode <= 1'b0;
      while (exp_left != 0) @(negedge ifclk);
      repeat (4) @(negedge ifclk);
      check(wr_fifo.size() == 0, "write data left over after the transfer");
      for (int i = 0; i < len; i++) begin
         check(mem_model[a + i] == ref_mem[a + i], $sformatf("memory word %0d is %h, expected %h",
               a + i, mem_model[a + i], ref_mem[a + i]));
      end
   endtask

   task automatic read_xfer(input int a, input int len);
      @(negedge ifclk);
      exp_instr = MEM_INSTR_READ;
      exp_addr  = mem_addr_t'(a * BYTES_PER_WORD);
      exp_left  = len;
      @(posedge ifclk);
      di_reg_addr  <= a;
      di_len       <= len;
      di_read_mode <= 1'b1;
      for (int i = 0; i < len; i++) begin
         @(negedge ifclk);
         while (!di_read_rdy) @(negedge ifclk);
         check(di_reg_datao == ref_mem[a + i], $sformatf("read word %0d is %h, expected %h",
               a + i, di_reg_datao, ref_mem[a + i]));
         @(posedge ifclk);
         di_read <= 1'b1;
         @(posedge ifclk);
         di_read <= 1'b0;
      end
      @(posedge ifclk);
      di_read_mode <= 1'b0;
      repeat (2) @(negedge ifclk);
      check(exp_left == 0 && rd_fifo.size() == 0, "read commands do not match the length");
      check(di_transfer_status == '0, "dram terminal reports a nonzero transfer status");
   endtask

   initial begin
      int         mark;
      term_addr_t ta;
      rst = 1'b1;
      {di_term_addr, di_reg_addr, di_len, di_reg_datai} = '0;
      {di_read_mode, di_write_mode, di_read, di_write} = '0;
      {pt_read_rdy, pt_write_rdy, pt_reg_datao, pt_transfer_status} = '0;
      {mem_cmd_full, mem_rd_data, busy} = '0;
      mem_rd_empty = 1'b1;
      {exp_left, strobes, errors, checks, cycles} = '0;
      for (int i = 0; i < 1024; i++) begin
         mem_model[i] = 32'hA5C30000 ^ (i * 32'h00010001);
         ref_mem[i]   = mem_model[i];
      end
      limit = 0;
      for (int k = 0; k < 2 * N_XFER; k++) begin
         wl[k] = rand_bits(6) % 40 + 1;
         rl[k] = rand_bits(6) % wl[k] + 1;
         wa[k] = rand_bits(10) % 980;
         limit += wl[k] + rl[k];
      end
      limit = 2 * limit + 2000;

      mark = errors;
      repeat (5) @(posedge ifclk);
      rst          <= 1'b0;
      di_term_addr <= TERM_DRAM;
      @(negedge ifclk);
      check(!mem_cmd_en && !mem_wr_en && di_write_rdy, "wrong memory port state after reset");
      report_test("reset state", mark);

      mark = errors;
      for (int i = 0; i < 20; i++) begin
         @(posedge ifclk);
         di_term_addr <= TERM_DUMMY_FPGA;
         di_reg_addr  <= rand_bits(32);
         @(negedge ifclk);
         check(di_reg_datao == ((di_reg_addr % 2 == 1) ? 32'hBBAA9988 : 32'h44556677),
               $sformatf("dummy answer %h for register %h", di_reg_datao, di_reg_addr));
         check(di_read_rdy && di_write_rdy && di_transfer_status == '0, "dummy flags wrong");
      end
      report_test("dummy terminal", mark);

      mark = errors;
      strobes = 0;
      for (int i = 0; i < 20; i++) begin
         ta = term_addr_t'(rand_bits(16));
         // keep clear of the dram and dummy terminals
         if (ta == TERM_DRAM || ta == TERM_DUMMY_FPGA)
            ta = ta ^ 16'h0100;
         @(posedge ifclk);
         di_term_addr       <= ta;
         {di_read, di_write} <= 2'(rand_bits(2));
         {pt_read_rdy, pt_write_rdy} <= 2'(rand_bits(2));
         pt_reg_datao       <= rand_bits(32);
         pt_transfer_status <= status_t'(rand_bits(16));
         @(negedge ifclk);
         check({di_read_rdy, di_write_rdy, di_reg_datao, di_transfer_status} ==
               {pt_read_rdy, pt_write_rdy, pt_reg_datao, pt_transfer_status},
               $sformatf("terminal %0d responses differ from the project inputs", ta));
      end
      @(posedge ifclk);
      {di_read, di_write} <= 2'b00;
      di_term_addr        <= TERM_DRAM;
      repeat (2) @(negedge ifclk);
      check(strobes == 0, "memory strobes fired for the project terminal");
      report_test("project", mark);

      mark = errors;
      for (int k = 0; k < N_XFER; k++)
         write_xfer(wa[k], wl[k]);
      report_test("write bursts", mark);
      mark = errors;
      for (int k = 0; k < N_XFER; k++)
         read_xfer(wa[k], rl[k]);
      report_test("read-back", mark);

      mark = errors;
      busy = 1'b1;
      for (int k = N_XFER; k < 2 * N_XFER; k++)
         write_xfer(wa[k], wl[k]);
      for (int k = N_XFER; k < 2 * N_XFER; k++)
         read_xfer(wa[k], rl[k]);
      busy = 1'b0;
      report_test("back-pressure", mark);

      $display("6 tests, %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* term_router.f */
rtl/term_pkg.sv
rtl/dram_cmd_if.sv
rtl/terminal_mux.sv
rtl/dram_cmd_builder.sv
rtl/dram_cmd_queue.sv
rtl/term_router_top.sv
testbench/tb_term_router.sv

/* Bender.yml */
package:
  name: term_router

sources:
  - rtl/term_pkg.sv
  - rtl/dram_cmd_if.sv
  - rtl/terminal_mux.sv
  - rtl/dram_cmd_builder.sv
  - rtl/dram_cmd_queue.sv
  - rtl/term_router_top.sv
  - target: test
    files:
      - testbench/tb_term_router.sv
